// ==== hw/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

  // vram side
  typedef logic [15:0] vram_addr_t;
  typedef logic [7:0]  vram_byte_t;

  // raw color index built from the two tile bitplanes
  typedef logic [1:0]  color_idx_t;

  // shade after the BGP palette lookup
  typedef logic [1:0]  shade_t;

  // visible x position, 0..159
  typedef logic [7:0]  screen_x_t;

  // column or row in the 32x32 tile map
  typedef logic [4:0]  tile_coord_t;

  // fetcher steps for one tile
  typedef enum logic [2:0] {
    get_tile,
    get_low,
    get_high,
    sleep,
    push
  } fetch_state_t;

  // tile map bases, picked by lcdc bit 3
  localparam vram_addr_t map_base_lo = 16'h9800;
  localparam vram_addr_t map_base_hi = 16'h9C00;

  // tile data bases, picked by lcdc bit 4
  // 8000 takes the index unsigned, 9000 takes it as a signed offset
  localparam vram_addr_t tile_base_unsigned = 16'h8000;
  localparam vram_addr_t tile_base_signed   = 16'h9000;

  // visible pixels per line
  localparam int screen_width = 160;

  // pixel fifo size, room for two full tile rows
  localparam int fifo_depth   = 16;
  // count has to reach fifo_depth itself
  localparam int fifo_count_w = 5;

endpackage

`default_nettype wire

// ==== hw/pixel_fifo_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface pixel_fifo_if;

  // fetcher side, one pixel per push pulse
  logic                push;
  ppu_pkg::color_idx_t push_px;

  // shifter side, pop_px is always the head entry
  logic                pop;
  ppu_pkg::color_idx_t pop_px;

  // fill levels from the fifo
  logic                full;
  logic                empty;

  modport producer (output push, output push_px, input empty, input full);

  modport buffer (
    input  push, input  push_px, input  pop,
    output pop_px, output full, output empty
  );

  modport consumer (output pop, input pop_px, input empty);

endinterface

`default_nettype wire

// ==== hw/bg_fetcher.sv ====
`timescale 1ns/1ns
`default_nettype none

module bg_fetcher (
  input  logic                clk,
  input  logic                reset,
  input  logic                line_start,
  input  logic                dot_en,
  input  logic [7:0]          ly,
  input  logic [7:0]          scx,
  input  logic [7:0]          scy,
  input  logic [7:0]          lcdc,
  input  ppu_pkg::vram_byte_t vram_rdata,
  output logic                vram_read_req,
  output ppu_pkg::vram_addr_t vram_addr,
  pixel_fifo_if.producer      fifo
);

  // absolute background line, wraps at 256
  logic [7:0] bg_y;

  // line values captured at line_start
  logic                 map_hi_q;
  logic                 data_unsigned_q;
  ppu_pkg::tile_coord_t coarse_x_q;
  ppu_pkg::tile_coord_t map_row_q;
  logic [2:0]           fine_row_q;

  // fetch progress
  ppu_pkg::fetch_state_t state;
  logic                  phase;
  ppu_pkg::tile_coord_t  tile_cnt;
  logic [2:0]            push_cnt;

  // fetched tile data, the row bytes shift out msb first
  ppu_pkg::vram_byte_t tile_idx;
  ppu_pkg::vram_byte_t low_sr;
  ppu_pkg::vram_byte_t high_sr;

  // address of the current map entry and tile row
  ppu_pkg::tile_coord_t map_col;
  ppu_pkg::vram_addr_t  map_addr;
  ppu_pkg::vram_addr_t  tile_addr;

  assign bg_y = scy + ly;

  // column wraps at 32 through the 5 bit add
  assign map_col = coarse_x_q + tile_cnt;

  // entry at row * 32 + col
  assign map_addr = (map_hi_q ? ppu_pkg::map_base_hi : ppu_pkg::map_base_lo) +
                    {6'b0, map_row_q, map_col};

  // index * 16 + fine row * 2
  // signed mode sign-extends the index so 128..255 land below 9000
  always_comb begin
    if (data_unsigned_q) begin
      tile_addr = ppu_pkg::tile_base_unsigned + {4'b0, tile_idx, fine_row_q, 1'b0};
    end else begin
      tile_addr = ppu_pkg::tile_base_signed +
                  {{4{tile_idx[7]}}, tile_idx, fine_row_q, 1'b0};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state           <= ppu_pkg::get_tile;
      phase           <= 1'b0;
      tile_cnt        <= '0;
      push_cnt        <= '0;
      vram_read_req   <= 1'b0;
      vram_addr       <= '0;
      fifo.push       <= 1'b0;
      map_hi_q        <= 1'b0;
      data_unsigned_q <= 1'b0;
      coarse_x_q      <= '0;
      map_row_q       <= '0;
      fine_row_q      <= '0;
    end else if (line_start) begin
      // restart at the first tile with the new register values
      state           <= ppu_pkg::get_tile;
      phase           <= 1'b0;
      tile_cnt        <= '0;
      push_cnt        <= '0;
      vram_read_req   <= 1'b0;
      fifo.push       <= 1'b0;
      map_hi_q        <= lcdc[3];
      data_unsigned_q <= lcdc[4];
      coarse_x_q      <= scx[7:3];
      map_row_q       <= bg_y[7:3];
      fine_row_q      <= bg_y[2:0];
    end else begin
      // both strobes last one cycle at most
      vram_read_req <= 1'b0;
      fifo.push     <= 1'b0;
      if (dot_en) begin
        unique case (state)
          ppu_pkg::get_tile: begin
            if (!phase) begin
              vram_addr     <= map_addr;
              vram_read_req <= 1'b1;
              phase         <= 1'b1;
            end else begin
              tile_idx <= vram_rdata;
              phase    <= 1'b0;
              state    <= ppu_pkg::get_low;
            end
          end
          ppu_pkg::get_low: begin
            if (!phase) begin
              vram_addr     <= tile_addr;
              vram_read_req <= 1'b1;
              phase         <= 1'b1;
            end else begin
              low_sr <= vram_rdata;
              // back to the first phase for the high byte
              phase  <= 1'b0;
              state  <= ppu_pkg::get_high;
            end
          end
          ppu_pkg::get_high: begin
            if (!phase) begin
              vram_addr     <= tile_addr + 16'd1;
              vram_read_req <= 1'b1;
              phase         <= 1'b1;
            end else begin
              high_sr <= vram_rdata;
              phase   <= 1'b0;
              state   <= ppu_pkg::sleep;
            end
          end
          ppu_pkg::sleep: begin
            // two idle dots
            phase <= !phase;
            if (phase) begin
              state <= ppu_pkg::push;
            end
          end
          ppu_pkg::push: begin
            // wait for an empty fifo, then push all 8 on consecutive dots
            if ((push_cnt != 3'd0 || fifo.empty) && !fifo.full) begin
              fifo.push    <= 1'b1;
              fifo.push_px <= {high_sr[7], low_sr[7]};
              high_sr      <= {high_sr[6:0], 1'b0};
              low_sr       <= {low_sr[6:0], 1'b0};
              push_cnt     <= push_cnt + 3'd1;
              if (push_cnt == 3'd7) begin
                tile_cnt <= tile_cnt + 5'd1;
                state    <= ppu_pkg::get_tile;
              end
            end
          end
          default: begin
            state <= ppu_pkg::get_tile;
            phase <= 1'b0;
          end
        endcase
      end
    end
  end

  // vram is only touched on enabled dots
  a_no_req_after_idle: assert property (
    @(posedge clk) disable iff (reset) !dot_en |=> !vram_read_req
  );

endmodule

`default_nettype wire

// ==== hw/bg_pixel_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module bg_pixel_fifo (
  input  logic          clk,
  input  logic          reset,
  input  logic          line_start,
  pixel_fifo_if.buffer  fifo
);

  localparam int ptr_w = $clog2(ppu_pkg::fifo_depth);

  // storage
  ppu_pkg::color_idx_t mem [ppu_pkg::fifo_depth];

  // pointers wrap on their own, depth is a power of two
  logic [ptr_w-1:0]                 wr_ptr;
  logic [ptr_w-1:0]                 rd_ptr;
  logic [ppu_pkg::fifo_count_w-1:0] count;

  // transfers that actually move data
  logic do_push;
  logic do_pop;

  assign fifo.full  = (count == ppu_pkg::fifo_count_w'(ppu_pkg::fifo_depth));
  assign fifo.empty = (count == '0);

  // head entry is visible before the pop
  assign fifo.pop_px = mem[rd_ptr];

  assign do_push = fifo.push && !fifo.full;
  assign do_pop  = fifo.pop && !fifo.empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= fifo.push_px;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (line_start) begin
      // drop whatever is left of the old line
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // fetcher only pushes into room
  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset) fifo.push |-> !fifo.full
  );

  // shifter only pops real pixels
  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset) fifo.pop |-> !fifo.empty
  );

endmodule

`default_nettype wire

// ==== hw/pixel_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_shifter (
  input  logic                clk,
  input  logic                reset,
  input  logic                line_start,
  input  logic                dot_en,
  input  logic [7:0]          scx,
  input  logic [7:0]          bgp,
  output logic                pix_valid,
  output ppu_pkg::shade_t     pix_shade,
  output ppu_pkg::screen_x_t  pix_x,
  output logic                line_done,
  pixel_fifo_if.consumer      fifo
);

  localparam ppu_pkg::screen_x_t last_x = ppu_pkg::screen_x_t'(ppu_pkg::screen_width - 1);

  // palette held for the line
  logic [7:0] bgp_q;

  // fine scroll pixels still to drop
  logic [2:0] discard_left;

  // next visible x and end of line flag
  ppu_pkg::screen_x_t x_cnt;
  logic               done;

  logic pop_now;

  // one pop per enabled dot until the line is complete
  assign pop_now  = dot_en && !fifo.empty && !done;
  assign fifo.pop = pop_now;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      discard_left <= '0;
      x_cnt        <= '0;
      done         <= 1'b0;
      pix_valid    <= 1'b0;
      line_done    <= 1'b0;
    end else if (line_start) begin
      discard_left <= scx[2:0];
      bgp_q        <= bgp;
      x_cnt        <= '0;
      done         <= 1'b0;
      pix_valid    <= 1'b0;
      line_done    <= 1'b0;
    end else begin
      pix_valid <= 1'b0;
      // one cycle after the last pixel
      line_done <= pix_valid && (pix_x == last_x);
      if (pop_now) begin
        if (discard_left != 3'd0) begin
          discard_left <= discard_left - 3'd1;
        end else begin
          pix_valid <= 1'b1;
          // shade n sits at bgp bits 2n+1:2n
          pix_shade <= bgp_q[{fifo.pop_px, 1'b0} +: 2];
          pix_x     <= x_cnt;
          x_cnt     <= x_cnt + 8'd1;
          if (x_cnt == last_x) begin
            done <= 1'b1;
          end
        end
      end
    end
  end

  // x stays on screen, popping stops at 160
  a_x_in_range: assert property (
    @(posedge clk) disable iff (reset) pix_valid |-> (pix_x <= last_x)
  );

endmodule

`default_nettype wire

// ==== hw/ppu_bg.sv ====
`timescale 1ns/1ns
`default_nettype none

module ppu_bg (
  input  logic                clk,
  input  logic                reset,
  input  logic                line_start,
  input  logic                dot_en,
  input  logic [7:0]          ly,
  input  logic [7:0]          scx,
  input  logic [7:0]          scy,
  input  logic [7:0]          lcdc,
  input  logic [7:0]          bgp,
  input  ppu_pkg::vram_byte_t vram_rdata,
  output logic                vram_read_req,
  output ppu_pkg::vram_addr_t vram_addr,
  output logic                pix_valid,
  output ppu_pkg::shade_t     pix_shade,
  output ppu_pkg::screen_x_t  pix_x,
  output logic                line_done
);

  // pixel path between the three blocks
  pixel_fifo_if u_fifo_if ();

  // tile map and tile data reads, pushes 8 pixels per tile
  bg_fetcher u_fetcher (
    .clk           (clk),
    .reset         (reset),
    .line_start    (line_start),
    .dot_en        (dot_en),
    .ly            (ly),
    .scx           (scx),
    .scy           (scy),
    .lcdc          (lcdc),
    .vram_rdata    (vram_rdata),
    .vram_read_req (vram_read_req),
    .vram_addr     (vram_addr),
    .fifo          (u_fifo_if.producer)
  );

  bg_pixel_fifo u_fifo (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .fifo       (u_fifo_if.buffer)
  );

  // fine scroll, palette and x count
  pixel_shifter u_shifter (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .dot_en     (dot_en),
    .scx        (scx),
    .bgp        (bgp),
    .pix_valid  (pix_valid),
    .pix_shade  (pix_shade),
    .pix_x      (pix_x),
    .line_done  (line_done),
    .fifo       (u_fifo_if.consumer)
  );

endmodule

`default_nettype wire

// ==== test/vram_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module vram_model (
  input  ppu_pkg::vram_addr_t addr,
  output ppu_pkg::vram_byte_t rdata
);

  // full 64 KiB space, only 8000..9FFF matters to the fetcher
  ppu_pkg::vram_byte_t mem [65536];

  // combinational read, the fetcher samples it one enabled dot later
  assign rdata = mem[addr];

  // background pattern built from every address bit
  initial begin
    for (int a = 0; a < 65536; a++) begin
      mem[a] = ppu_pkg::vram_byte_t'((a >> 8) ^ (a * 37) ^ (a >> 13));
    end
  end

  // random tile data over both addressing windows, 8000..97FF
  task automatic randomize_tiles();
    for (int a = 16'h8000; a < 16'h9800; a++) begin
      mem[a] = ppu_pkg::vram_byte_t'($urandom);
    end
  endtask

  // random tile indices in both maps, 9800..9FFF
  task automatic randomize_maps();
    for (int a = 16'h9800; a < 16'hA000; a++) begin
      mem[a] = ppu_pkg::vram_byte_t'($urandom);
    end
  endtask

  // one map entry at base + row * 32 + col
  task automatic set_map_entry(input ppu_pkg::vram_addr_t base, input int row, input int col,
                               input ppu_pkg::vram_byte_t idx);
    mem[base + ppu_pkg::vram_addr_t'(row * 32 + col)] = idx;
  endtask

  // one tile row, low bitplane first then high
  task automatic load_tile_row(input ppu_pkg::vram_addr_t row_addr,
                               input ppu_pkg::vram_byte_t lo, input ppu_pkg::vram_byte_t hi);
    mem[row_addr]         = lo;
    mem[row_addr + 16'd1] = hi;
  endtask

endmodule

`default_nettype wire

// ==== test/tb_ppu_bg.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ppu_bg;

  // worst case dots for one line
  // the watchdog covers six of them
  localparam int line_limit      = 160 * 4 * 20;
  localparam int watchdog_cycles = 6 * line_limit;

  logic                clk;
  logic                reset;
  logic                line_start;
  logic                dot_en;
  logic [7:0]          ly;
  logic [7:0]          scx;
  logic [7:0]          scy;
  logic [7:0]          lcdc;
  logic [7:0]          bgp;
  ppu_pkg::vram_byte_t vram_rdata;
  logic                vram_read_req;
  ppu_pkg::vram_addr_t vram_addr;
  logic                pix_valid;
  ppu_pkg::shade_t     pix_shade;
  ppu_pkg::screen_x_t  pix_x;
  logic                line_done;

  int          mismatch_cnt = 0;
  int          failure_cnt  = 0;
  // per line progress that line_start or reset clears
  int          pix_cnt      = 0;
  int          done_cnt     = 0;
  int          read_cnt     = 0;
  logic        dot_en_prev  = 1'b0;

  ppu_bg u_dut (
    .clk           (clk),
    .reset         (reset),
    .line_start    (line_start),
    .dot_en        (dot_en),
    .ly            (ly),
    .scx           (scx),
    .scy           (scy),
    .lcdc          (lcdc),
    .bgp           (bgp),
    .vram_rdata    (vram_rdata),
    .vram_read_req (vram_read_req),
    .vram_addr     (vram_addr),
    .pix_valid     (pix_valid),
    .pix_shade     (pix_shade),
    .pix_x         (pix_x),
    .line_done     (line_done)
  );

  vram_model u_vram (
    .addr  (vram_addr),
    .rdata (vram_rdata)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // map entry read for the given tile of this line
  function automatic ppu_pkg::vram_addr_t map_entry_addr(input int tile);
    logic [7:0]          bg_y;
    logic [4:0]          col;
    ppu_pkg::vram_addr_t base;
    bg_y = scy + ly;
    // column wraps at 32
    col  = scx[7:3] + 5'(tile);
    base = lcdc[3] ? ppu_pkg::map_base_hi : ppu_pkg::map_base_lo;
    return base + 16'(bg_y[7:3]) * 16'd32 + 16'(col);
  endfunction

  // low byte address of the current tile row
  function automatic ppu_pkg::vram_addr_t tile_row_addr(input ppu_pkg::vram_byte_t idx);
    logic [7:0] bg_y;
    int         offset;
    bg_y = scy + ly;
    if (lcdc[4]) begin
      offset = int'(ppu_pkg::tile_base_unsigned) + int'(idx) * 16;
    end else begin
      // 9000 mode takes the index as -128..127
      offset = int'(ppu_pkg::tile_base_signed) +
               ((idx >= 8'd128) ? int'(idx) - 256 : int'(idx)) * 16;
    end
    return ppu_pkg::vram_addr_t'(offset + int'(bg_y[2:0]) * 2);
  endfunction

  // n-th vram read of the line
  // each tile reads its map entry, then the low and high bytes
  function automatic ppu_pkg::vram_addr_t read_addr_at(input int n);
    ppu_pkg::vram_addr_t map_addr;
    map_addr = map_entry_addr(n / 3);
    case (n % 3)
      0:       return map_addr;
      1:       return tile_row_addr(u_vram.mem[map_addr]);
      default: return tile_row_addr(u_vram.mem[map_addr]) + 16'd1;
    endcase
  endfunction

  // visible pixel x counts from the first kept pixel
  function automatic ppu_pkg::shade_t expected_shade(input int x);
    int                  pos;
    int                  b;
    ppu_pkg::vram_addr_t row_addr;
    ppu_pkg::vram_byte_t lo;
    ppu_pkg::vram_byte_t hi;
    logic [1:0]          color;
    pos      = int'(scx[2:0]) + x;
    row_addr = tile_row_addr(u_vram.mem[map_entry_addr(pos / 8)]);
    lo       = u_vram.mem[row_addr];
    hi       = u_vram.mem[row_addr + 16'd1];
    // leftmost pixel is bit 7
    b        = 7 - pos % 8;
    color    = {hi[b], lo[b]};
    return bgp[2 * color +: 2];
  endfunction

  task automatic check_shade(input ppu_pkg::shade_t got, input ppu_pkg::shade_t exp,
                             input int x);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: shade at x %0d is %0d, expected %0d", $time, x, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_x(input ppu_pkg::screen_x_t got, input ppu_pkg::screen_x_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: pix_x is %0d, expected %0d", $time, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_addr(input ppu_pkg::vram_addr_t got, input ppu_pkg::vram_addr_t exp,
                            input int n);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: vram read %0d at %h, expected %h", $time, n, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%0t ns: %s", $time, msg);
    failure_cnt++;
  endtask

  // samples on every edge the outputs that the previous edge set
  always @(posedge clk) begin
    if (reset || line_start) begin
      pix_cnt  = 0;
      done_cnt = 0;
      read_cnt = 0;
    end else begin
      if (pix_valid) begin
        if (!dot_en_prev) note_failure("pixel appeared after a disabled dot");
        if (done_cnt != 0) begin
          note_failure("pixel appeared after line_done");
        end else begin
          check_x(pix_x, ppu_pkg::screen_x_t'(pix_cnt));
          check_shade(pix_shade, expected_shade(pix_cnt), pix_cnt);
        end
        pix_cnt++;
      end
      if (line_done) begin
        done_cnt++;
        if (done_cnt > 1) note_failure("line_done pulsed more than once");
      end
      if (vram_read_req) begin
        if (!dot_en_prev) note_failure("vram read raised after a disabled dot");
        check_addr(vram_addr, read_addr_at(read_cnt), read_cnt);
        read_cnt++;
      end
    end
    dot_en_prev = dot_en;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // registers stay put for the whole line
  task automatic start_line(input logic [7:0] scx_v, input logic [7:0] scy_v,
                            input logic [7:0] ly_v, input logic [7:0] lcdc_v,
                            input logic [7:0] bgp_v);
    @(posedge clk);
    scx        <= scx_v;
    scy        <= scy_v;
    ly         <= ly_v;
    lcdc       <= lcdc_v;
    bgp        <= bgp_v;
    dot_en     <= 1'b0;
    line_start <= 1'b1;
    @(posedge clk);
    line_start <= 1'b0;
  endtask

  // stop_px of 0 runs to line_done
  task automatic drive_dots(input bit gaps, input int stop_px, output bit reached);
    int n;
    n       = 0;
    reached = 1'b0;
    while (!reached && n < line_limit) begin
      @(posedge clk);
      dot_en <= gaps ? ($urandom_range(3) != 0) : 1'b1;
      @(negedge clk);
      n++;
      if (done_cnt > 0 || (stop_px > 0 && pix_cnt >= stop_px)) reached = 1'b1;
    end
  endtask

  task automatic run_line(input bit gaps);
    bit reached;
    drive_dots(gaps, 0, reached);
    if (!reached) begin
      note_failure($sformatf("line_done missing after %0d dots", line_limit));
    end else if (pix_cnt != ppu_pkg::screen_width) begin
      note_failure($sformatf("line ended after %0d pixels instead of 160", pix_cnt));
    end
    // extra dots catch stray pixels or a second line_done
    repeat (24) begin
      @(posedge clk);
      dot_en <= 1'b1;
    end
    @(posedge clk);
    dot_en <= 1'b0;
  endtask

  task automatic plain_line();
    // tiles 0..31 across map row 0 with random data in row 0 of each
    for (int c = 0; c < 32; c++) begin
      u_vram.set_map_entry(ppu_pkg::map_base_lo, 0, c, ppu_pkg::vram_byte_t'(c));
      u_vram.load_tile_row(ppu_pkg::tile_base_unsigned + ppu_pkg::vram_addr_t'(c * 16),
                           ppu_pkg::vram_byte_t'($urandom), ppu_pkg::vram_byte_t'($urandom));
    end
    start_line(8'h00, 8'h00, 8'h00, 8'h91, 8'hE4);
    run_line(1'b0);
  endtask

  task automatic horizontal_scroll();
    // start at column 31 with 3 pixels dropped
    start_line(8'hFB, 8'h00, 8'h05, 8'h91, 8'h1B);
    run_line(1'b0);
  endtask

  task automatic vertical_select();
    start_line(8'h00, 8'h0C, 8'h03, 8'h91, 8'hE4);
    run_line(1'b0);
    // scy + ly wraps past 255
    start_line(8'h13, 8'hF8, 8'h16, 8'h91, 8'h93);
    run_line(1'b0);
    start_line(8'h44, 8'h37, 8'h64, 8'h91, 8'h4E);
    run_line(1'b0);
  endtask

  task automatic map_and_data_select();
    start_line(8'h10, 8'h20, 8'h09, 8'h99, 8'hD2);
    run_line(1'b0);
    // row 5 indices step by 8 so columns 16 and up land at 128..255
    for (int c = 0; c < 32; c++) begin
      u_vram.set_map_entry(ppu_pkg::map_base_lo, 5, c, ppu_pkg::vram_byte_t'(c * 8));
    end
    start_line(8'h00, 8'h00, 8'h2A, 8'h81, 8'h6C);
    run_line(1'b0);
    start_line(8'h80, 8'h00, 8'h2A, 8'h81, 8'h6C);
    run_line(1'b0);
  endtask

  task automatic dot_gaps();
    start_line(8'h2D, 8'h51, 8'h77, 8'h91, 8'h9C);
    run_line(1'b1);
  endtask

  task automatic mid_line_restart();
    bit reached;
    start_line(8'h05, 8'h10, 8'h20, 8'h91, 8'hE4);
    drive_dots(1'b0, 40, reached);
    start_line(8'hA6, 8'h33, 8'h41, 8'h89, 8'h27);
    run_line(1'b0);
    // reset in the middle of a line instead
    start_line(8'h3F, 8'h02, 8'h90, 8'h99, 8'hB1);
    drive_dots(1'b1, 70, reached);
    @(posedge clk);
    dot_en <= 1'b0;
    reset  <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    start_line(8'h07, 8'hC4, 8'h0B, 8'h81, 8'hE4);
    run_line(1'b0);
  endtask

  initial begin
    // seed the random generator once
    void'($urandom(32'h2dbc));
    reset      = 1'b1;
    line_start = 1'b0;
    dot_en     = 1'b0;
    ly         = 8'h00;
    scx        = 8'h00;
    scy        = 8'h00;
    lcdc       = 8'h91;
    bgp        = 8'hE4;
    repeat (2) @(posedge clk);
    // random tiles and maps over the background pattern of the model
    u_vram.randomize_tiles();
    u_vram.randomize_maps();
    reset <= 1'b0;
    plain_line();
    horizontal_scroll();
    vertical_select();
    map_and_data_select();
    dot_gaps();
    mid_line_restart();
    repeat (4) @(posedge clk);
    $display("checks done: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
    if (mismatch_cnt == 0 && failure_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/ppu_pkg.sv
hw/pixel_fifo_if.sv
hw/bg_fetcher.sv
hw/bg_pixel_fifo.sv
hw/pixel_shifter.sv
hw/ppu_bg.sv
test/vram_model.sv
test/tb_ppu_bg.sv

// ==== Bender.yml ====
package:
  name: ppu_bg

sources:
  # background pixel path RTL
  - target: rtl
    files:
      - hw/ppu_pkg.sv
      - hw/pixel_fifo_if.sv
      - hw/bg_fetcher.sv
      - hw/bg_pixel_fifo.sv
      - hw/pixel_shifter.sv
      - hw/ppu_bg.sv
  # testbench, top module tb_ppu_bg
  - target: test
    files:
      - test/vram_model.sv
      - test/tb_ppu_bg.sv
